/* logic/datapath_pkg.sv */
// shared ISA fields, opcode and state encodings and widths for the scalar core datapath
`default_nettype none

package datapath_pkg;

    // data and address width
    localparam int word_w = 32;

    // register file geometry
    localparam int reg_cnt = 16;
    localparam int reg_w = 4;

    // immediate field, sign-extended to word_w
    localparam int imm_w = 16;

    // byte increment of the program counter
    localparam int pc_step = 4;

    // instruction word field positions
    localparam int op_hi = 31;
    localparam int op_lo = 28;
    localparam int rd_hi = 27;
    localparam int rd_lo = 24;
    localparam int rs1_hi = 23;
    localparam int rs1_lo = 20;
    localparam int rs2_hi = 19;
    localparam int rs2_lo = 16;

    // opcodes 12 to 15 are unused and behave as no-ops
    typedef enum logic [3:0] {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_and  = 4'd2,
        op_or   = 4'd3,
        op_xor  = 4'd4,
        op_addi = 4'd5,
        op_lw   = 4'd6,
        op_sw   = 4'd7,
        op_beq  = 4'd8,
        op_bne  = 4'd9,
        op_jal  = 4'd10,
        op_halt = 4'd11
    } opcode_t;

    // functional unit that an instruction goes to
    typedef enum logic [1:0] {
        fu_alu  = 2'd0,
        fu_ls   = 2'd1,
        fu_br   = 2'd2,
        fu_none = 2'd3
    } fu_t;

    // four-phase data memory handshake
    typedef enum logic [1:0] {
        ls_idle    = 2'd0,
        ls_req     = 2'd1,
        ls_release = 2'd2
    } ls_state_t;

endpackage

`default_nettype wire

/* logic/fetch_stage.sv */
// program counter and fetch latch, steps through instruction memory and follows redirects
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  logic                            CLK,
    input  logic                            nrst,
    input  logic                            freeze,
    input  logic                            redirect,
    input  logic [datapath_pkg::word_w-1:0] redirect_pc,
    input  logic [datapath_pkg::word_w-1:0] imem_data,
    output logic [datapath_pkg::word_w-1:0] imem_addr,
    output logic [datapath_pkg::word_w-1:0] f_instr,
    output logic [datapath_pkg::word_w-1:0] f_pc,
    output logic                            f_valid
);

    logic [datapath_pkg::word_w-1:0] pc;

    // instruction memory answers within the cycle
    assign imem_addr = pc;

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            pc <= '0;
            f_valid <= 1'b0;
        end else if (redirect) begin
            // the instruction fetched this cycle is on the wrong path
            pc <= redirect_pc;
            f_valid <= 1'b0;
        end else if (!freeze) begin
            pc <= pc + datapath_pkg::word_w'(datapath_pkg::pc_step);
            f_valid <= 1'b1;
        end
    end

    // fetch latch payload
    always_ff @(posedge CLK) begin
        if (!redirect && !freeze) begin
            f_instr <= imem_data;
            f_pc <= pc;
        end
    end

endmodule

`default_nettype wire

/* logic/scoreboard.sv */
// decode, register file and busy tracking; issues one instruction per cycle into the issue latch
`timescale 1ns/1ps
`default_nettype none

module scoreboard (
    input  logic                            CLK,
    input  logic                            nrst,
    input  logic [datapath_pkg::word_w-1:0] f_instr,
    input  logic [datapath_pkg::word_w-1:0] f_pc,
    input  logic                            f_valid,
    input  logic                            ex_busy,
    input  logic                            redirect,
    input  logic                            halt,
    input  logic                            wb_en,
    input  logic [datapath_pkg::reg_w-1:0]  wb_rd,
    input  logic [datapath_pkg::word_w-1:0] wb_data,
    output logic                            freeze,
    output logic                            ex_valid,
    output datapath_pkg::opcode_t           ex_op,
    output logic [datapath_pkg::reg_w-1:0]  ex_rd,
    output logic [datapath_pkg::word_w-1:0] ex_a,
    output logic [datapath_pkg::word_w-1:0] ex_b,
    output logic [datapath_pkg::word_w-1:0] ex_imm,
    output logic [datapath_pkg::word_w-1:0] ex_pc
);

    datapath_pkg::opcode_t              op;
    logic [datapath_pkg::reg_w-1:0]     rd;
    logic [datapath_pkg::reg_w-1:0]     rs1;
    logic [datapath_pkg::reg_w-1:0]     rs2;
    logic [datapath_pkg::word_w-1:0]    imm;
    logic                               uses_rs1;
    logic                               uses_rs2;
    logic                               writes_rd;
    logic [datapath_pkg::word_w-1:0]    rf [datapath_pkg::reg_cnt];
    logic [datapath_pkg::reg_cnt-1:0]   busy;
    logic [datapath_pkg::reg_cnt-1:0]   busy_eff;
    logic [datapath_pkg::reg_cnt-1:0]   wb_clr;
    logic [datapath_pkg::word_w-1:0]    rdat1;
    logic [datapath_pkg::word_w-1:0]    rdat2;
    logic                               hazard;
    logic                               stop;
    logic                               issue;

    // field split
    assign op = datapath_pkg::opcode_t'(f_instr[datapath_pkg::op_hi:datapath_pkg::op_lo]);
    assign rd = f_instr[datapath_pkg::rd_hi:datapath_pkg::rd_lo];
    assign rs1 = f_instr[datapath_pkg::rs1_hi:datapath_pkg::rs1_lo];
    assign rs2 = f_instr[datapath_pkg::rs2_hi:datapath_pkg::rs2_lo];
    assign imm = {{(datapath_pkg::word_w - datapath_pkg::imm_w){f_instr[datapath_pkg::imm_w-1]}},
                  f_instr[datapath_pkg::imm_w-1:0]};

    always_comb begin
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        writes_rd = 1'b0;
        case (op)
            datapath_pkg::op_add, datapath_pkg::op_sub, datapath_pkg::op_and,
            datapath_pkg::op_or, datapath_pkg::op_xor: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                writes_rd = 1'b1;
            end
            datapath_pkg::op_addi, datapath_pkg::op_lw: begin
                uses_rs1 = 1'b1;
                writes_rd = 1'b1;
            end
            datapath_pkg::op_sw, datapath_pkg::op_beq, datapath_pkg::op_bne: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            datapath_pkg::op_jal: writes_rd = 1'b1;
            default: ;
        endcase
    end

    // a writeback landing this cycle frees its register now
    assign wb_clr = wb_en ? (datapath_pkg::reg_cnt'(1) << wb_rd) : '0;
    assign busy_eff = busy & ~wb_clr;

    // r0 reads zero, same-cycle writeback is forwarded
    assign rdat1 = (rs1 == '0) ? '0 : (wb_en && wb_rd == rs1) ? wb_data : rf[rs1];
    assign rdat2 = (rs2 == '0) ? '0 : (wb_en && wb_rd == rs2) ? wb_data : rf[rs2];

    assign hazard = (uses_rs1 && busy_eff[rs1]) || (uses_rs2 && busy_eff[rs2])
                  || (writes_rd && busy_eff[rd]);
    // nothing issues behind a halt
    assign stop = halt || (ex_valid && ex_op == datapath_pkg::op_halt);
    assign issue = f_valid && !redirect && !ex_busy && !stop && !hazard;
    assign freeze = stop || ex_busy || (f_valid && hazard);

    always_ff @(posedge CLK) begin
        if (wb_en) begin
            rf[wb_rd] <= wb_data;
        end
    end

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            busy <= '0;
        end else if (issue && writes_rd && rd != '0) begin
            busy <= busy_eff | (datapath_pkg::reg_cnt'(1) << rd);
        end else begin
            busy <= busy_eff;
        end
    end

    // issue latch, held while a memory access is in flight
    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            ex_valid <= 1'b0;
        end else if (redirect) begin
            ex_valid <= 1'b0;
        end else if (!ex_busy) begin
            ex_valid <= issue;
        end
    end

    always_ff @(posedge CLK) begin
        if (issue) begin
            ex_op <= op;
            ex_rd <= rd;
            ex_a <= rdat1;
            ex_b <= rdat2;
            ex_imm <= imm;
            ex_pc <= f_pc;
        end
    end

    // a source still owned by an older instruction must never be read
    a_no_busy_src: assert property (@(posedge CLK) disable iff (!nrst)
        issue |-> (!uses_rs1 || !busy[rs1] || (wb_en && wb_rd == rs1))
               && (!uses_rs2 || !busy[rs2] || (wb_en && wb_rd == rs2)));

endmodule

`default_nettype wire

/* logic/execute.sv */
// ALU, branch resolution and scalar load/store over a four-phase data memory handshake
`timescale 1ns/1ps
`default_nettype none

module execute (
    input  logic                            CLK,
    input  logic                            nrst,
    input  logic                            ex_valid,
    input  datapath_pkg::opcode_t           ex_op,
    input  logic [datapath_pkg::reg_w-1:0]  ex_rd,
    input  logic [datapath_pkg::word_w-1:0] ex_a,
    input  logic [datapath_pkg::word_w-1:0] ex_b,
    input  logic [datapath_pkg::word_w-1:0] ex_imm,
    input  logic [datapath_pkg::word_w-1:0] ex_pc,
    input  logic                            dmem_ack,
    input  logic [datapath_pkg::word_w-1:0] dmem_rdata,
    output logic                            ex_busy,
    output logic                            res_valid,
    output logic [datapath_pkg::reg_w-1:0]  res_rd,
    output logic [datapath_pkg::word_w-1:0] res_data,
    output logic                            res_wen,
    output logic                            redirect,
    output logic [datapath_pkg::word_w-1:0] redirect_pc,
    output logic                            halt,
    output logic                            dmem_req,
    output logic                            dmem_wen,
    output logic [datapath_pkg::word_w-1:0] dmem_addr,
    output logic [datapath_pkg::word_w-1:0] dmem_wdata
);

    datapath_pkg::fu_t                  fu;
    datapath_pkg::ls_state_t            ls_state;
    logic [datapath_pkg::word_w-1:0]    alu_y;
    logic [datapath_pkg::word_w-1:0]    ld_q;
    logic                               ls_done;

    always_comb begin
        case (ex_op)
            datapath_pkg::op_add, datapath_pkg::op_sub, datapath_pkg::op_and,
            datapath_pkg::op_or, datapath_pkg::op_xor,
            datapath_pkg::op_addi: fu = datapath_pkg::fu_alu;
            datapath_pkg::op_lw, datapath_pkg::op_sw: fu = datapath_pkg::fu_ls;
            datapath_pkg::op_beq, datapath_pkg::op_bne,
            datapath_pkg::op_jal: fu = datapath_pkg::fu_br;
            default: fu = datapath_pkg::fu_none;
        endcase
    end

    always_comb begin
        case (ex_op)
            datapath_pkg::op_add:  alu_y = ex_a + ex_b;
            datapath_pkg::op_sub:  alu_y = ex_a - ex_b;
            datapath_pkg::op_and:  alu_y = ex_a & ex_b;
            datapath_pkg::op_or:   alu_y = ex_a | ex_b;
            datapath_pkg::op_xor:  alu_y = ex_a ^ ex_b;
            datapath_pkg::op_addi: alu_y = ex_a + ex_imm;
            // link value
            datapath_pkg::op_jal:  alu_y = ex_pc + datapath_pkg::word_w'(datapath_pkg::pc_step);
            default:               alu_y = '0;
        endcase
    end

    // predicted not taken, so any taken branch or jal redirects
    assign redirect = ex_valid && ((ex_op == datapath_pkg::op_beq && ex_a == ex_b)
                    || (ex_op == datapath_pkg::op_bne && ex_a != ex_b)
                    || ex_op == datapath_pkg::op_jal);
    assign redirect_pc = ex_pc + ex_imm;

    // access completes once ack has fallen again
    assign ls_done = (ls_state == datapath_pkg::ls_release) && !dmem_ack;
    assign ex_busy = (ls_state == datapath_pkg::ls_idle && ex_valid && fu == datapath_pkg::fu_ls)
                   || ls_state == datapath_pkg::ls_req
                   || (ls_state == datapath_pkg::ls_release && dmem_ack);

    assign dmem_req = (ls_state == datapath_pkg::ls_req);
    assign dmem_wen = dmem_req && ex_op == datapath_pkg::op_sw;
    assign dmem_addr = ex_a + ex_imm;
    assign dmem_wdata = ex_b;

    assign res_valid = (ex_valid && (fu == datapath_pkg::fu_alu || fu == datapath_pkg::fu_br))
                     || ls_done;
    assign res_wen = fu == datapath_pkg::fu_alu || ex_op == datapath_pkg::op_jal
                   || ex_op == datapath_pkg::op_lw;
    assign res_rd = ex_rd;
    assign res_data = (fu == datapath_pkg::fu_ls) ? ld_q : alu_y;

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            ls_state <= datapath_pkg::ls_idle;
        end else begin
            case (ls_state)
                datapath_pkg::ls_idle:
                    if (ex_valid && fu == datapath_pkg::fu_ls) ls_state <= datapath_pkg::ls_req;
                datapath_pkg::ls_req:
                    if (dmem_ack) ls_state <= datapath_pkg::ls_release;
                datapath_pkg::ls_release:
                    if (!dmem_ack) ls_state <= datapath_pkg::ls_idle;
                default: ls_state <= datapath_pkg::ls_idle;
            endcase
        end
    end

    // read data is only valid while ack is high
    always_ff @(posedge CLK) begin
        if (ls_state == datapath_pkg::ls_req && dmem_ack) begin
            ld_q <= dmem_rdata;
        end
    end

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            halt <= 1'b0;
        end else if (ex_valid && ex_op == datapath_pkg::op_halt) begin
            halt <= 1'b1;
        end
    end

    a_req_hold: assert property (@(posedge CLK) disable iff (!nrst)
        dmem_req && !dmem_ack |=> dmem_req);

    // a new request only starts after the previous ack fell
    a_req_restart: assert property (@(posedge CLK) disable iff (!nrst)
        $rose(dmem_req) |-> !$past(dmem_ack));

endmodule

`default_nettype wire

/* logic/writeback.sv */
// writeback latch, returns the finished result to the register file and frees its busy bit
`timescale 1ns/1ps
`default_nettype none

module writeback (
    input  logic                            CLK,
    input  logic                            nrst,
    input  logic                            res_valid,
    input  logic [datapath_pkg::reg_w-1:0]  res_rd,
    input  logic [datapath_pkg::word_w-1:0] res_data,
    input  logic                            res_wen,
    output logic                            wb_en,
    output logic [datapath_pkg::reg_w-1:0]  wb_rd,
    output logic [datapath_pkg::word_w-1:0] wb_data
);

    // stores and branches retire here too but write nothing
    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            wb_en <= 1'b0;
        end else begin
            wb_en <= res_valid && res_wen && res_rd != '0;
        end
    end

    always_ff @(posedge CLK) begin
        if (res_valid) begin
            wb_rd <= res_rd;
            wb_data <= res_data;
        end
    end

endmodule

`default_nettype wire

/* logic/sc_datapath.sv */
// scalar core top level, wires fetch, scoreboard, execute and writeback to the memory ports
`timescale 1ns/1ps
`default_nettype none

module sc_datapath (
    input  logic                            CLK,
    input  logic                            nrst,
    input  logic [datapath_pkg::word_w-1:0] imem_data,
    input  logic                            dmem_ack,
    input  logic [datapath_pkg::word_w-1:0] dmem_rdata,
    output logic [datapath_pkg::word_w-1:0] imem_addr,
    output logic                            dmem_req,
    output logic                            dmem_wen,
    output logic [datapath_pkg::word_w-1:0] dmem_addr,
    output logic [datapath_pkg::word_w-1:0] dmem_wdata,
    output logic                            halt
);

    // fetch latch
    logic [datapath_pkg::word_w-1:0] f_instr;
    logic [datapath_pkg::word_w-1:0] f_pc;
    logic                            f_valid;
    logic                            freeze;

    // issue latch
    logic                            ex_valid;
    datapath_pkg::opcode_t           ex_op;
    logic [datapath_pkg::reg_w-1:0]  ex_rd;
    logic [datapath_pkg::word_w-1:0] ex_a;
    logic [datapath_pkg::word_w-1:0] ex_b;
    logic [datapath_pkg::word_w-1:0] ex_imm;
    logic [datapath_pkg::word_w-1:0] ex_pc;
    logic                            ex_busy;

    // execute result and redirect
    logic                            res_valid;
    logic [datapath_pkg::reg_w-1:0]  res_rd;
    logic [datapath_pkg::word_w-1:0] res_data;
    logic                            res_wen;
    logic                            redirect;
    logic [datapath_pkg::word_w-1:0] redirect_pc;

    // register write port
    logic                            wb_en;
    logic [datapath_pkg::reg_w-1:0]  wb_rd;
    logic [datapath_pkg::word_w-1:0] wb_data;

    fetch_stage u_fetch (
        .CLK, .nrst, .freeze, .redirect, .redirect_pc, .imem_data,
        .imem_addr, .f_instr, .f_pc, .f_valid
    );

    scoreboard u_scoreboard (
        .CLK, .nrst, .f_instr, .f_pc, .f_valid, .ex_busy, .redirect, .halt,
        .wb_en, .wb_rd, .wb_data,
        .freeze, .ex_valid, .ex_op, .ex_rd, .ex_a, .ex_b, .ex_imm, .ex_pc
    );

    execute u_execute (
        .CLK, .nrst, .ex_valid, .ex_op, .ex_rd, .ex_a, .ex_b, .ex_imm, .ex_pc,
        .dmem_ack, .dmem_rdata,
        .ex_busy, .res_valid, .res_rd, .res_data, .res_wen, .redirect, .redirect_pc, .halt,
        .dmem_req, .dmem_wen, .dmem_addr, .dmem_wdata
    );

    writeback u_writeback (
        .CLK, .nrst, .res_valid, .res_rd, .res_data, .res_wen,
        .wb_en, .wb_rd, .wb_data
    );

endmodule

`default_nettype wire

/* test/tb_sc_datapath.sv */
// testbench for sc_datapath, runs a fixed program and checks every data store against an ISA model
`timescale 1ns/1ps
`default_nettype none

module tb_sc_datapath;

    logic        CLK = 1'b0;
    logic        nrst;
    logic [31:0] imem_data;
    logic        dmem_ack;
    logic [31:0] dmem_rdata;
    logic [31:0] imem_addr;
    logic        dmem_req;
    logic        dmem_wen;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        halt;

    logic [31:0] imem [64];
    logic [31:0] dmem [256];
    int          prog_len;
    int          exp_access_cnt;
    int          limit_cycles;
    int          checked_cnt;
    bit          exp_halt;
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] got_addr [$];
    logic [31:0] got_data [$];

    sc_datapath uut (
        .CLK, .nrst, .imem_data, .dmem_ack, .dmem_rdata,
        .imem_addr, .dmem_req, .dmem_wen, .dmem_addr, .dmem_wdata, .halt
    );

    always #50 CLK = ~CLK;

    // combinational word read
    assign imem_data = imem[imem_addr[7:2]];

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error: %s expected %h actual %h", name, expected, actual);
            stop_run("a checked value did not match");
        end
    endtask

    function automatic logic [31:0] fill_word(input int idx);
        return (32'(idx) * 32'h9e3779b1) ^ 32'h0badf00d;
    endfunction

    function automatic logic [31:0] encode(input datapath_pkg::opcode_t op, input int rd,
                                           input int rs1, input int rs2, input int imm);
        return {op, 4'(rd), 4'(rs1), 4'(rs2), 16'(imm)};
    endfunction

    task automatic put(input datapath_pkg::opcode_t op, input int rd, input int rs1,
                       input int rs2, input int imm);
        imem[6'(prog_len)] = encode(op, rd, rs1, rs2, imm);
        prog_len++;
    endtask

    // sequential ISA model, collects the expected stores in program order
    function automatic bit run_reference();
        logic [31:0]           regs [16];
        logic [31:0]           mem [256];
        logic [31:0]           pc;
        logic [31:0]           ins;
        logic [31:0]           a;
        logic [31:0]           b;
        logic [31:0]           imm;
        logic [31:0]           ea;
        logic [31:0]           res;
        logic [3:0]            rd;
        datapath_pkg::opcode_t op;
        bit                    halted;
        int                    steps;
        for (int i = 0; i < 16; i++) regs[4'(i)] = '0;
        for (int i = 0; i < 256; i++) mem[8'(i)] = fill_word(i);
        pc = '0;
        halted = 1'b0;
        steps = 0;
        while (!halted && steps < 1000) begin
            ins = imem[pc[7:2]];
            op = datapath_pkg::opcode_t'(ins[31:28]);
            rd = ins[27:24];
            a = regs[ins[23:20]];
            b = regs[ins[19:16]];
            imm = {{16{ins[15]}}, ins[15:0]};
            ea = a + imm;
            case (op)
                datapath_pkg::op_add:  res = a + b;
                datapath_pkg::op_sub:  res = a - b;
                datapath_pkg::op_and:  res = a & b;
                datapath_pkg::op_or:   res = a | b;
                datapath_pkg::op_xor:  res = a ^ b;
                datapath_pkg::op_addi: res = a + imm;
                datapath_pkg::op_lw:   res = mem[ea[9:2]];
                datapath_pkg::op_jal:  res = pc + 32'd4;
                default:               res = '0;
            endcase
            if (op == datapath_pkg::op_sw) begin
                mem[ea[9:2]] = b;
                exp_addr.push_back(ea);
                exp_data.push_back(b);
            end
            if (op == datapath_pkg::op_lw || op == datapath_pkg::op_sw) exp_access_cnt++;
            if (rd != 4'd0 && op inside {datapath_pkg::op_add, datapath_pkg::op_sub,
                datapath_pkg::op_and, datapath_pkg::op_or, datapath_pkg::op_xor,
                datapath_pkg::op_addi, datapath_pkg::op_lw, datapath_pkg::op_jal}) begin
                regs[rd] = res;
            end
            // taken branches and jal are relative to their own pc
            if ((op == datapath_pkg::op_beq && a == b) || (op == datapath_pkg::op_bne && a != b)
                || op == datapath_pkg::op_jal) begin
                pc = pc + imm;
            end else begin
                pc = pc + 32'd4;
            end
            halted = (op == datapath_pkg::op_halt);
            steps++;
        end
        return halted;
    endfunction

    task automatic load_program();
        for (int i = 0; i < 64; i++) imem[6'(i)] = encode(datapath_pkg::op_halt, 0, 0, 0, 0);
        prog_len = 0;
        // ALU ops with back-to-back RAW chains
        put(datapath_pkg::op_addi, 1, 0, 0, 'h1234);
        put(datapath_pkg::op_addi, 2, 0, 0, -3);
        put(datapath_pkg::op_add, 3, 1, 2, 0);
        put(datapath_pkg::op_sub, 4, 3, 1, 0);
        put(datapath_pkg::op_and, 5, 1, 3, 0);
        put(datapath_pkg::op_or, 6, 4, 1, 0);
        put(datapath_pkg::op_xor, 7, 6, 2, 0);
        put(datapath_pkg::op_sw, 0, 0, 3, 'h100);
        put(datapath_pkg::op_sw, 0, 0, 4, 'h104);
        put(datapath_pkg::op_sw, 0, 0, 5, 'h108);
        put(datapath_pkg::op_sw, 0, 0, 6, 'h10c);
        put(datapath_pkg::op_sw, 0, 0, 7, 'h110);
        // WAW on r8
        put(datapath_pkg::op_addi, 8, 1, 0, 5);
        put(datapath_pkg::op_addi, 8, 8, 0, 7);
        put(datapath_pkg::op_add, 8, 8, 8, 0);
        put(datapath_pkg::op_sw, 0, 0, 8, 'h114);
        // loads with dependent use
        put(datapath_pkg::op_lw, 9, 0, 0, 'h104);
        put(datapath_pkg::op_addi, 10, 9, 0, 1);
        put(datapath_pkg::op_sw, 0, 0, 10, 'h118);
        put(datapath_pkg::op_lw, 11, 0, 0, 'h40);
        put(datapath_pkg::op_xor, 12, 11, 9, 0);
        put(datapath_pkg::op_sw, 0, 0, 12, 'h11c);
        // branches not taken
        put(datapath_pkg::op_beq, 0, 1, 2, 16);
        put(datapath_pkg::op_sw, 0, 0, 1, 'h120);
        put(datapath_pkg::op_bne, 0, 1, 1, 16);
        put(datapath_pkg::op_sw, 0, 0, 2, 'h124);
        // taken beq, bne and jal, each followed by two wrong-path slots
        put(datapath_pkg::op_beq, 0, 3, 3, 12);
        put(datapath_pkg::op_sw, 0, 0, 1, 'h1f0);
        put(datapath_pkg::op_sw, 0, 0, 2, 'h1f4);
        put(datapath_pkg::op_bne, 0, 1, 2, 12);
        put(datapath_pkg::op_sw, 0, 0, 1, 'h1f8);
        // wrong-path write over a live register
        put(datapath_pkg::op_addi, 5, 0, 0, 'h77);
        put(datapath_pkg::op_jal, 14, 0, 0, 12);
        put(datapath_pkg::op_sw, 0, 0, 1, 'h1fc);
        put(datapath_pkg::op_sw, 0, 0, 2, 'h1e0);
        put(datapath_pkg::op_sw, 0, 0, 14, 'h128);
        put(datapath_pkg::op_sw, 0, 0, 5, 'h12c);
        put(datapath_pkg::op_halt, 0, 0, 0, 0);
        // never reached
        put(datapath_pkg::op_sw, 0, 0, 1, 'h1e4);
    endtask

    // four-phase responder with a random ack delay
    initial begin : dmem_responder
        int unsigned ack_wait;
        bit          pending;
        void'($urandom(32'hfeda));
        for (int i = 0; i < 256; i++) dmem[8'(i)] = fill_word(i);
        dmem_ack = 1'b0;
        dmem_rdata = '0;
        pending = 1'b0;
        ack_wait = 0;
        forever begin
            @(posedge CLK);
            #5;
            if (dmem_ack) begin
                if (!dmem_req) dmem_ack = 1'b0;
            end else if (dmem_req) begin
                if (!pending) begin
                    pending = 1'b1;
                    ack_wait = $urandom_range(7, 0);
                end
                if (ack_wait != 0) begin
                    ack_wait--;
                end else begin
                    if (dmem_wen) begin
                        dmem[dmem_addr[9:2]] = dmem_wdata;
                        got_addr.push_back(dmem_addr);
                        got_data.push_back(dmem_wdata);
                    end else begin
                        dmem_rdata = dmem[dmem_addr[9:2]];
                    end
                    dmem_ack = 1'b1;
                    pending = 1'b0;
                end
            end
        end
    end

    initial begin : compare_stores
        logic [31:0] addr;
        logic [31:0] data;
        checked_cnt = 0;
        forever begin
            @(negedge CLK);
            while (got_addr.size() != 0) begin
                addr = got_addr.pop_front();
                data = got_data.pop_front();
                if (checked_cnt >= exp_addr.size()) begin
                    stop_run($sformatf("unexpected store of %h to address %h", data, addr));
                end else begin
                    check($sformatf("store %0d address", checked_cnt), exp_addr[checked_cnt], addr);
                    check($sformatf("store %0d data", checked_cnt), exp_data[checked_cnt], data);
                    checked_cnt++;
                end
            end
        end
    end

    initial begin : handshake_monitor
        logic prev_req;
        logic prev_ack;
        prev_req = 1'b0;
        prev_ack = 1'b0;
        forever begin
            @(negedge CLK);
            if (nrst && dmem_req && !prev_req && prev_ack) begin
                stop_run("dmem_req rose again while dmem_ack was still high");
            end else if (halt && dmem_req) begin
                stop_run("dmem_req was raised after halt");
            end
            prev_req = dmem_req;
            prev_ack = dmem_ack;
        end
    end

    initial begin : watchdog
        wait (limit_cycles != 0);
        repeat (limit_cycles) @(posedge CLK);
        stop_run("timeout, the program did not reach halt in time");
    end

    initial begin : main_sequence
        nrst = 1'b0;
        exp_access_cnt = 0;
        limit_cycles = 0;
        load_program();
        exp_halt = run_reference();
        limit_cycles = 16 + prog_len * 200 + exp_access_cnt * 8;
        repeat (16) begin
            @(posedge CLK);
            #5;
            check("reset dmem_req", 32'd0, 32'(dmem_req));
            check("reset dmem_wen", 32'd0, 32'(dmem_wen));
            check("reset halt", 32'd0, 32'(halt));
            check("reset imem_addr", 32'd0, imem_addr);
        end
        nrst = 1'b1;
        wait (halt === 1'b1);
        // a few more cycles so a stray request would show up
        repeat (8) @(posedge CLK);
        #5;
        check("final halt", 32'(exp_halt), 32'(halt));
        check("store count", 32'(exp_addr.size()), 32'(checked_cnt));
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
logic/datapath_pkg.sv
logic/fetch_stage.sv
logic/scoreboard.sv
logic/execute.sv
logic/writeback.sv
logic/sc_datapath.sv
test/tb_sc_datapath.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, and decide the result from the log
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_sc_datapath -f verilog.f > build.log 2>&1 \
    && ./obj_dir/Vtb_sc_datapath > sim.log 2>&1
cat build.log sim.log 2>/dev/null
grep -q "Simulation finished: PASS" sim.log 2>/dev/null \
    && echo "run passed" \
    || { echo "run failed"; exit 1; }
